/* rtl/cache_pkg.sv */
// ----------------------------
// Blocking cache package
// Sizes, message types and the controller/datapath bundles
// ----------------------------
package cache_pkg;

  // Geometry
  localparam int NUM_LINES      = 16;
  localparam int LINE_BYTES     = 16;
  localparam int WORD_W         = 32;
  localparam int ADDR_W         = 32;
  localparam int LINE_W         = LINE_BYTES * 8;
  localparam int WORDS_PER_LINE = LINE_W / WORD_W;
  localparam int IDX_W          = $clog2(NUM_LINES);
  localparam int OFS_W          = $clog2(LINE_BYTES);
  localparam int WOFS_W         = $clog2(WORDS_PER_LINE);
  // Tag keeps every address bit above the line offset
  localparam int TAG_W          = ADDR_W - OFS_W;

  typedef enum logic [2:0] {
    MEM_READ  = 3'd0,
    MEM_WRITE = 3'd1,
    MEM_INIT  = 3'd2
  } mem_type_e;

  // ----------------------------
  // Requester and memory messages
  // ----------------------------
  typedef struct packed {
    mem_type_e          req_type;
    logic [ADDR_W-1:0]  addr;
    logic [WORD_W-1:0]  data;
  } cache_req_t;

  typedef struct packed {
    mem_type_e          resp_type;
    logic               hit;
    logic [WORD_W-1:0]  data;
  } cache_resp_t;

  // Address is line aligned, data only meaningful on writes
  typedef struct packed {
    mem_type_e          req_type;
    logic [ADDR_W-1:0]  addr;
    logic [LINE_W-1:0]  data;
  } mem_req_t;

  typedef struct packed {
    mem_type_e          resp_type;
    logic [LINE_W-1:0]  data;
  } mem_resp_t;

  // ----------------------------
  // Controller to datapath
  // ----------------------------
  typedef struct packed {
    logic                       cachereq_en;
    logic                       memresp_en;
    logic                       wdata_sel;        // 0 request word, 1 refill line
    logic                       tag_wen;
    logic                       data_ren;
    logic                       data_wen;
    logic [WORDS_PER_LINE-1:0]  word_wen;
    logic                       read_reg_en;
    logic                       evict_addr_en;
    logic                       memreq_addr_sel;  // 0 refill, 1 victim
  } ctrl_sig_t;

  // Datapath back to controller
  typedef struct packed {
    mem_type_e          req_type;
    logic [IDX_W-1:0]   idx;
    logic [WOFS_W-1:0]  word_ofs;
    logic               tag_match;
  } dpath_status_t;

endpackage

/* rtl/cache_ctrl.sv */
// ----------------------------
// Blocking cache controller
// FSM, valid/dirty bits and the per-state control table
// ----------------------------
`timescale 1ns/1ps

module cache_ctrl
  import cache_pkg::*;
(
  input  logic           clk,
  input  logic           reset,

  input  logic           cachereq_val,
  output logic           cachereq_rdy,

  output logic           cacheresp_val,
  input  logic           cacheresp_rdy,

  output logic           memreq_val,
  input  logic           memreq_rdy,

  input  logic           memresp_val,
  output logic           memresp_rdy,

  input  dpath_status_t  status,
  output ctrl_sig_t      ctrl,
  output logic           resp_hit
);

  typedef enum logic [3:0] {
    ST_IDLE, ST_TAG_CHECK, ST_INIT_ACCESS, ST_READ_ACCESS, ST_WRITE_ACCESS,
    ST_REFILL_REQUEST, ST_REFILL_WAIT, ST_REFILL_UPDATE,
    ST_EVICT_PREPARE, ST_EVICT_REQUEST, ST_EVICT_WAIT, ST_WAIT
  } state_e;

  typedef enum logic [1:0] {D_KEEP, D_SET, D_CLR} dirty_act_e;

  state_e                     state;
  state_e                     state_next;
  logic [NUM_LINES-1:0]       valid;
  logic [NUM_LINES-1:0]       dirty;
  logic                       hit;

  logic                       hit_en;
  logic                       valid_set;
  dirty_act_e                 dirty_act;

  logic [NUM_LINES-1:0]       line_sel;
  logic [WORDS_PER_LINE-1:0]  word_sel;
  logic                       hit_now;

  assign line_sel = NUM_LINES'(1) << status.idx;
  // One word per access, full line only on refill
  assign word_sel = WORDS_PER_LINE'(1) << status.word_ofs;
  assign hit_now  = status.tag_match && (status.req_type != MEM_INIT) && valid[status.idx];
  assign resp_hit = hit;

  // ----------------------------
  // State and line bits
  // ----------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      valid <= '0;
      dirty <= '0;
      hit   <= 1'b0;
    end else begin
      state <= state_next;
      // Line becomes valid once the response is taken
      if (valid_set && cacheresp_rdy)
        valid <= valid | line_sel;
      case (dirty_act)
        D_SET:   dirty <= dirty | line_sel;
        D_CLR:   dirty <= dirty & ~line_sel;
        default: dirty <= dirty;
      endcase
      if (hit_en)
        hit <= hit_now;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE:           if (cachereq_val) state_next = ST_TAG_CHECK;
      ST_TAG_CHECK: begin
        if (status.req_type == MEM_INIT)
          state_next = ST_INIT_ACCESS;
        else if (hit_now)
          state_next = (status.req_type == MEM_WRITE) ? ST_WRITE_ACCESS : ST_READ_ACCESS;
        else if (dirty[status.idx])
          state_next = ST_EVICT_PREPARE;
        else
          state_next = ST_REFILL_REQUEST;
      end
      ST_INIT_ACCESS:    state_next = ST_WAIT;
      ST_READ_ACCESS:    state_next = ST_WAIT;
      ST_WRITE_ACCESS:   state_next = ST_WAIT;
      ST_REFILL_REQUEST: if (memreq_rdy) state_next = ST_REFILL_WAIT;
      ST_REFILL_WAIT:    if (memresp_val) state_next = ST_REFILL_UPDATE;
      ST_REFILL_UPDATE:
        state_next = (status.req_type == MEM_WRITE) ? ST_WRITE_ACCESS : ST_READ_ACCESS;
      ST_EVICT_PREPARE:  state_next = ST_EVICT_REQUEST;
      ST_EVICT_REQUEST:  if (memreq_rdy) state_next = ST_EVICT_WAIT;
      ST_EVICT_WAIT:     if (memresp_val) state_next = ST_REFILL_REQUEST;
      ST_WAIT:           if (cacheresp_rdy) state_next = ST_IDLE;
      default:           state_next = ST_IDLE;
    endcase
  end

  // ----------------------------
  // Control table
  // ----------------------------
  task automatic cs(
    input logic                       t_req_rdy,
    input logic                       t_resp_val,
    input logic                       t_mreq_val,
    input logic                       t_mresp_rdy,
    input logic                       t_req_en,
    input logic                       t_mresp_en,
    input logic                       t_wdata_sel,
    input logic                       t_tag_wen,
    input logic                       t_data_ren,
    input logic                       t_data_wen,
    input logic [WORDS_PER_LINE-1:0]  t_word_wen,
    input logic                       t_read_en,
    input logic                       t_evict_en,
    input logic                       t_addr_sel,
    input logic                       t_hit_en,
    input logic                       t_valid_set,
    input dirty_act_e                 t_dirty
  );
    cachereq_rdy         = t_req_rdy;
    cacheresp_val        = t_resp_val;
    memreq_val           = t_mreq_val;
    memresp_rdy          = t_mresp_rdy;
    ctrl.cachereq_en     = t_req_en;
    ctrl.memresp_en      = t_mresp_en;
    ctrl.wdata_sel       = t_wdata_sel;
    ctrl.tag_wen         = t_tag_wen;
    ctrl.data_ren        = t_data_ren;
    ctrl.data_wen        = t_data_wen;
    ctrl.word_wen        = t_word_wen;
    ctrl.read_reg_en     = t_read_en;
    ctrl.evict_addr_en   = t_evict_en;
    ctrl.memreq_addr_sel = t_addr_sel;
    hit_en               = t_hit_en;
    valid_set            = t_valid_set;
    dirty_act            = t_dirty;
  endtask

  always_comb begin
    case (state)
      //                  qr rv mv mr qe me ws tw dr dw wwen      rd ev as he vs dirty
      ST_IDLE:           cs(1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 4'h0,     0, 0, 0, 0, 0, D_KEEP);
      ST_TAG_CHECK:      cs(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 4'h0,     0, 0, 0, 1, 0, D_KEEP);
      ST_INIT_ACCESS:    cs(0, 0, 0, 0, 0, 0, 0, 1, 0, 1, word_sel, 0, 0, 0, 0, 0, D_KEEP);
      ST_READ_ACCESS:    cs(0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 4'h0,     1, 0, 0, 0, 0, D_KEEP);
      ST_WRITE_ACCESS:   cs(0, 0, 0, 0, 0, 0, 0, 0, 0, 1, word_sel, 0, 0, 0, 0, 0, D_SET);
      ST_REFILL_REQUEST: cs(0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 4'h0,     0, 0, 0, 0, 0, D_KEEP);
      ST_REFILL_WAIT:    cs(0, 0, 0, 1, 0, 1, 0, 0, 0, 0, 4'h0,     0, 0, 0, 0, 0, D_KEEP);
      ST_REFILL_UPDATE:  cs(0, 0, 0, 0, 0, 0, 1, 1, 0, 1, 4'hf,     0, 0, 0, 0, 0, D_KEEP);
      ST_EVICT_PREPARE:  cs(0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 4'h0,     1, 1, 0, 0, 0, D_CLR);
      ST_EVICT_REQUEST:  cs(0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 4'h0,     0, 0, 1, 0, 0, D_KEEP);
      ST_EVICT_WAIT:     cs(0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 4'h0,     0, 0, 1, 0, 0, D_KEEP);
      ST_WAIT:           cs(0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 4'h0,     0, 0, 0, 0, 1, D_KEEP);
      default:           cs(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 4'h0,     0, 0, 0, 0, 0, D_KEEP);
    endcase
  end

endmodule

/* rtl/cache_dpath.sv */
// ----------------------------
// Blocking cache datapath
// Request register, tag/data arrays and message builders
// ----------------------------
`timescale 1ns/1ps

module cache_dpath
  import cache_pkg::*;
(
  input  logic           clk,
  input  logic           reset,

  input  cache_req_t     cachereq,
  input  mem_resp_t      memresp,
  input  ctrl_sig_t      ctrl,
  input  logic           resp_hit,

  output dpath_status_t  status,
  output cache_resp_t    cacheresp,
  output mem_req_t       memreq
);

  cache_req_t          req_reg;
  logic [LINE_W-1:0]   refill_line;
  logic [LINE_W-1:0]   read_line;
  logic [ADDR_W-1:0]   evict_addr;

  logic [TAG_W-1:0]    tag_array  [NUM_LINES];
  logic [LINE_W-1:0]   data_array [NUM_LINES];

  logic [IDX_W-1:0]    idx;
  logic [WOFS_W-1:0]   word_ofs;
  logic [TAG_W-1:0]    req_tag;
  logic [TAG_W-1:0]    tag_rd;
  logic [LINE_W-1:0]   data_rd;
  logic [LINE_W-1:0]   wr_line;
  logic [ADDR_W-1:0]   refill_addr;

  // Address split of the registered request
  assign idx         = req_reg.addr[OFS_W +: IDX_W];
  assign word_ofs    = req_reg.addr[OFS_W-1 -: WOFS_W];
  assign req_tag     = req_reg.addr[ADDR_W-1 -: TAG_W];
  assign refill_addr = {req_tag, {OFS_W{1'b0}}};

  assign tag_rd  = tag_array[idx];
  assign data_rd = ctrl.data_ren ? data_array[idx] : '0;

  // Request word copied to every slot, word enables pick the one written
  assign wr_line = ctrl.wdata_sel ? refill_line : {WORDS_PER_LINE{req_reg.data}};

  // ----------------------------
  // Input registers
  // ----------------------------
  always_ff @(posedge clk) begin
    if (reset)
      req_reg <= '0;
    else if (ctrl.cachereq_en)
      req_reg <= cachereq;
  end

  always_ff @(posedge clk) begin
    if (ctrl.memresp_en)
      refill_line <= memresp.data;
  end

  // ----------------------------
  // Arrays
  // ----------------------------
  always_ff @(posedge clk) begin
    if (ctrl.tag_wen)
      tag_array[idx] <= req_tag;
  end

  always_ff @(posedge clk) begin
    if (ctrl.data_wen) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        if (ctrl.word_wen[w])
          data_array[idx][w*WORD_W +: WORD_W] <= wr_line[w*WORD_W +: WORD_W];
      end
    end
  end

  // Line read for a response or for eviction, victim address from the old tag
  always_ff @(posedge clk) begin
    if (ctrl.read_reg_en)
      read_line <= data_rd;
    if (ctrl.evict_addr_en)
      evict_addr <= {tag_rd, {OFS_W{1'b0}}};
  end

  // ----------------------------
  // Status and outgoing messages
  // ----------------------------
  always_comb begin
    status.req_type  = req_reg.req_type;
    status.idx       = idx;
    status.word_ofs  = word_ofs;
    status.tag_match = (tag_rd == req_tag);
  end

  always_comb begin
    cacheresp.resp_type = req_reg.req_type;
    cacheresp.hit       = resp_hit;
    // Only reads return data
    if (req_reg.req_type == MEM_READ)
      cacheresp.data = read_line[word_ofs*WORD_W +: WORD_W];
    else
      cacheresp.data = '0;
  end

  always_comb begin
    if (ctrl.memreq_addr_sel) begin
      memreq.req_type = MEM_WRITE;
      memreq.addr     = evict_addr;
    end else begin
      memreq.req_type = MEM_READ;
      memreq.addr     = refill_addr;
    end
    memreq.data = read_line;
  end

endmodule

/* rtl/blocking_cache.sv */
// ----------------------------
// Direct-mapped write-back blocking cache
// ----------------------------
`timescale 1ns/1ps

module blocking_cache
  import cache_pkg::*;
(
  input  logic         clk,
  input  logic         reset,

  // Requester side
  input  logic         cachereq_val,
  output logic         cachereq_rdy,
  input  cache_req_t   cachereq,

  output logic         cacheresp_val,
  input  logic         cacheresp_rdy,
  output cache_resp_t  cacheresp,

  // Memory side
  output logic         memreq_val,
  input  logic         memreq_rdy,
  output mem_req_t     memreq,

  input  logic         memresp_val,
  output logic         memresp_rdy,
  input  mem_resp_t    memresp
);

  ctrl_sig_t      ctrl;
  dpath_status_t  status;
  logic           resp_hit;

  cache_ctrl i_cache_ctrl (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .status        (status),
    .ctrl          (ctrl),
    .resp_hit      (resp_hit)
  );

  cache_dpath i_cache_dpath (
    .clk       (clk),
    .reset     (reset),
    .cachereq  (cachereq),
    .memresp   (memresp),
    .ctrl      (ctrl),
    .resp_hit  (resp_hit),
    .status    (status),
    .cacheresp (cacheresp),
    .memreq    (memreq)
  );

endmodule

/* test/test_mem.sv */
// ------------------------------
// Main memory model
// Line-wide storage, random latency and a write-back log
// ------------------------------
`timescale 1ns/1ps

module test_mem
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       memreq_val,
  output logic       memreq_rdy,
  input  mem_req_t   memreq,
  output logic       memresp_val,
  input  logic       memresp_rdy,
  output mem_resp_t  memresp
);

  logic [LINE_W-1:0]  lines [logic [ADDR_W-1:0]];
  logic [ADDR_W-1:0]  wb_addr_q [$];
  logic [LINE_W-1:0]  wb_line_q [$];
  int unsigned        req_count;
  mem_resp_t          resp_next;
  logic               pending;
  int unsigned        delay;

  // Same fill as the testbench reference
  function automatic logic [WORD_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return {a[15:0] ^ 16'h5a3c, a[31:16] ^ 16'h0f17};
  endfunction

  function automatic logic [LINE_W-1:0] read_line(input logic [ADDR_W-1:0] a);
    logic [LINE_W-1:0] l;
    if (lines.exists(a))
      return lines[a];
    for (int w = 0; w < WORDS_PER_LINE; w++)
      l[w*WORD_W +: WORD_W] = fill_word(a + 32'(4 * w));
    return l;
  endfunction

  initial begin
    memreq_rdy  = 1'b0;
    memresp_val = 1'b0;
    memresp     = '0;
    resp_next   = '0;
    pending     = 1'b0;
    delay       = 0;
    req_count   = 0;
  end

  always @(posedge clk) begin
    if (reset) begin
      pending = 1'b0;
    end else begin
      if (memresp_val && memresp_rdy)
        pending = 1'b0;
      if (memreq_val && memreq_rdy) begin
        req_count++;
        resp_next.resp_type = memreq.req_type;
        if (memreq.req_type == MEM_WRITE) begin
          lines[memreq.addr] = memreq.data;
          wb_addr_q.push_back(memreq.addr);
          wb_line_q.push_back(memreq.data);
          resp_next.data = '0;
        end else begin
          resp_next.data = read_line(memreq.addr);
        end
        pending = 1'b1;
        delay   = $urandom_range(1, 6);
      end else if (pending && delay != 0) begin
        delay--;
      end
    end
    #1;
    memresp_val = pending && (delay == 0);
    memresp     = resp_next;
    // Ready drops now and then while idle
    memreq_rdy  = !reset && !pending && ($urandom_range(0, 3) != 0);
  end

endmodule

/* test/cache_ctrl_chk.sv */
// ------------------------------
// Controller handshake checks
// ------------------------------
`timescale 1ns/1ps

module cache_ctrl_chk (
  input logic clk,
  input logic reset,
  input logic cachereq_rdy,
  input logic cacheresp_val,
  input logic cacheresp_rdy,
  input logic memreq_val,
  input logic memreq_rdy
);

  // Failures seen so far
  int unsigned fail_count = 0;

  a_req_resp_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(cachereq_rdy && cacheresp_val))
    else begin
      $error("cachereq_rdy and cacheresp_val high in the same cycle");
      fail_count++;
    end

  a_memreq_hold: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val)
    else begin
      $error("memreq_val dropped before memreq_rdy");
      fail_count++;
    end

  a_cacheresp_hold: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val)
    else begin
      $error("cacheresp_val dropped before cacheresp_rdy");
      fail_count++;
    end

endmodule

bind cache_ctrl cache_ctrl_chk i_cache_ctrl_chk (
  .clk           (clk),
  .reset         (reset),
  .cachereq_rdy  (cachereq_rdy),
  .cacheresp_val (cacheresp_val),
  .cacheresp_rdy (cacheresp_rdy),
  .memreq_val    (memreq_val),
  .memreq_rdy    (memreq_rdy)
);

/* test/tb_blocking_cache.sv */
// ------------------------------
// Blocking cache testbench
// Directed and random traffic against a reference model
// ------------------------------
`timescale 1ns/1ps

module tb_blocking_cache;
  import cache_pkg::*;

  localparam int     RAND_OPS   = 80;
  // Directed requests plus the worst case of four per random operation
  localparam int     MAX_REQS   = 17 + 4 * RAND_OPS;
  localparam int     MEM_TRIP   = 16;
  localparam longint TIMEOUT_NS = longint'(MAX_REQS) * (2 * MEM_TRIP + 10) * 10;

  logic         clk = 1'b0;
  logic         reset = 1'b1;
  logic         cachereq_val;
  logic         cachereq_rdy;
  cache_req_t   cachereq;
  logic         cacheresp_val;
  logic         cacheresp_rdy = 1'b0;
  cache_resp_t  cacheresp;
  logic         memreq_val;
  logic         memreq_rdy;
  mem_req_t     memreq;
  logic         memresp_val;
  logic         memresp_rdy;
  mem_resp_t    memresp;

  // Reference mirror of the cache and memory
  logic [TAG_W-1:0]   ref_tag   [NUM_LINES];
  logic               ref_valid [NUM_LINES];
  logic               ref_dirty [NUM_LINES];
  logic [LINE_W-1:0]  ref_line  [NUM_LINES];
  logic [WORD_W-1:0]  ref_mem   [logic [ADDR_W-1:0]];

  cache_resp_t        exp_q [$];
  string              name_q [$];
  logic [ADDR_W-1:0]  exp_wb_addr_q [$];
  logic [LINE_W-1:0]  exp_wb_line_q [$];
  cache_resp_t        exp_r;
  string              exp_name;
  string              test_name;
  int                 errors;
  int                 checks;
  int                 tests_run;
  int                 tests_failed;
  int                 err_mark;
  int                 cycle;
  int                 accept_cycle;
  int                 rise_cycle;
  logic               resp_val_q;
  bit                 stall_en;

  blocking_cache i_blocking_cache (.*);

  test_mem i_test_mem (.clk, .reset, .memreq_val, .memreq_rdy, .memreq,
                       .memresp_val, .memresp_rdy, .memresp);

  always #5 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [WORD_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return {a[15:0] ^ 16'h5a3c, a[31:16] ^ 16'h0f17};
  endfunction

  function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  function automatic string format_resp(input cache_resp_t r);
    return $sformatf("type=%0d hit=%0b data=%h", r.resp_type, r.hit, r.data);
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic cache_resp_t ref_access(input mem_type_e t, input logic [ADDR_W-1:0] a,
                                             input logic [WORD_W-1:0] d);
    cache_resp_t        r;
    logic [IDX_W-1:0]   i;
    logic [TAG_W-1:0]   tg;
    logic [ADDR_W-1:0]  base;
    int                 w;
    i = a[OFS_W +: IDX_W];
    tg = a[ADDR_W-1 -: TAG_W];
    w = int'(a[3:2]);
    r.resp_type = t;
    r.data = '0;
    r.hit = ref_valid[i] && (ref_tag[i] == tg) && (t != MEM_INIT);
    if (t != MEM_INIT && !r.hit) begin
      // Dirty victim goes back before the refill
      if (ref_dirty[i]) begin
        base = {ref_tag[i], 4'h0};
        exp_wb_addr_q.push_back(base);
        exp_wb_line_q.push_back(ref_line[i]);
        for (int k = 0; k < WORDS_PER_LINE; k++)
          ref_mem[base + 32'(4 * k)] = ref_line[i][k*WORD_W +: WORD_W];
        ref_dirty[i] = 1'b0;
      end
      base = {tg, 4'h0};
      for (int k = 0; k < WORDS_PER_LINE; k++)
        ref_line[i][k*WORD_W +: WORD_W] = mem_word(base + 32'(4 * k));
    end
    // Init installs the tag but keeps the dirty bit
    ref_tag[i] = tg;
    ref_valid[i] = 1'b1;
    if (t == MEM_READ)
      r.data = ref_line[i][w*WORD_W +: WORD_W];
    else
      ref_line[i][w*WORD_W +: WORD_W] = d;
    if (t == MEM_WRITE)
      ref_dirty[i] = 1'b1;
    return r;
  endfunction

  // ------------------------------
  // Response comparison
  // ------------------------------
  always @(posedge clk) begin
    #1;
    cacheresp_rdy = reset ? 1'b0 : (stall_en ? ($urandom_range(0, 3) != 0) : 1'b1);
    if (!reset) begin
      if (cacheresp_val && !resp_val_q)
        rise_cycle = cycle;
      resp_val_q = cacheresp_val;
      if (cacheresp_val && cacheresp_rdy) begin
        checks++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("%s: response arrived with no request outstanding", test_name);
        end else begin
          exp_r = exp_q.pop_front();
          exp_name = name_q.pop_front();
          if (cacheresp !== exp_r) begin
            errors++;
            $display("CHECK FAILED %s: expected %s, actual %s", exp_name,
                     format_resp(exp_r), format_resp(cacheresp));
          end
        end
      end
    end
  end

  task automatic send_req(input mem_type_e t, input logic [ADDR_W-1:0] a,
                          input logic [WORD_W-1:0] d);
    exp_q.push_back(ref_access(t, a, d));
    name_q.push_back(test_name);
    cachereq_val = 1'b1;
    cachereq.req_type = t;
    cachereq.addr = a;
    cachereq.data = d;
    while (!cachereq_rdy) begin
      @(posedge clk);
      #1;
    end
    accept_cycle = cycle;
    @(posedge clk);
    #1;
    cachereq_val = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_writebacks();
    logic [ADDR_W-1:0] ea;
    logic [ADDR_W-1:0] ma;
    logic [LINE_W-1:0] el;
    logic [LINE_W-1:0] ml;
    while (exp_wb_addr_q.size() != 0 || i_test_mem.wb_addr_q.size() != 0) begin
      checks++;
      if (exp_wb_addr_q.size() == 0) begin
        errors++;
        ma = i_test_mem.wb_addr_q.pop_front();
        ml = i_test_mem.wb_line_q.pop_front();
        $display("%s: unexpected write-back to address %h", test_name, ma);
      end else if (i_test_mem.wb_addr_q.size() == 0) begin
        errors++;
        ea = exp_wb_addr_q.pop_front();
        el = exp_wb_line_q.pop_front();
        $display("%s: missing write-back to address %h", test_name, ea);
      end else begin
        ea = exp_wb_addr_q.pop_front();
        el = exp_wb_line_q.pop_front();
        ma = i_test_mem.wb_addr_q.pop_front();
        ml = i_test_mem.wb_line_q.pop_front();
        if (ea !== ma || el !== ml) begin
          errors++;
          $display("CHECK FAILED %s: expected wb %h line %h, actual wb %h line %h",
                   test_name, ea, el, ma, ml);
        end
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    drain();
    check_writebacks();
    tests_run++;
    if (errors != err_mark)
      tests_failed++;
    $display("test %s: %s", test_name, (errors == err_mark) ? "ok" : "errors");
  endtask

  // ------------------------------
  // Watchdog
  // ------------------------------
  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: run timed out after %0d ns, %0d responses still outstanding",
             TIMEOUT_NS, exp_q.size());
    $display("Testbench failed");
    $finish;
  end

  initial begin
    logic [ADDR_W-1:0] a;
    int unsigned       m;
    int unsigned       op;
    int unsigned       asrt_fails;
    void'($urandom(32'h68c23b50));
    cachereq_val = 1'b0;
    cachereq = '0;
    stall_en = 1'b0;
    resp_val_q = 1'b0;
    for (int i = 0; i < NUM_LINES; i++) begin
      ref_valid[i] = 1'b0;
      ref_dirty[i] = 1'b0;
    end
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    start_test("read_miss_then_hit");
    send_req(MEM_READ, 32'h0000_1004, '0);
    send_req(MEM_READ, 32'h0000_1008, '0);
    drain();
    checks++;
    if (rise_cycle - accept_cycle != 3) begin
      errors++;
      $display("CHECK FAILED %s: expected latency 3, actual %0d", test_name,
               rise_cycle - accept_cycle);
    end
    end_test();

    start_test("write_hit_read_back");
    send_req(MEM_WRITE, 32'h0000_100c, 32'hdead_beef);
    for (int k = 3; k >= 0; k--)
      send_req(MEM_READ, 32'h0000_1000 + 32'(4 * k), '0);
    end_test();

    start_test("init_line");
    m = i_test_mem.req_count;
    for (int k = 0; k < 4; k++)
      send_req(MEM_INIT, 32'h0000_2040 + 32'(4 * k), 32'h1111_0000 + 32'(k));
    for (int k = 0; k < 4; k++)
      send_req(MEM_READ, 32'h0000_2040 + 32'(4 * k), '0);
    drain();
    checks++;
    if (i_test_mem.req_count != m) begin
      errors++;
      $display("CHECK FAILED %s: expected %0d memory requests, actual %0d", test_name,
               m, i_test_mem.req_count);
    end
    end_test();

    start_test("dirty_eviction");
    send_req(MEM_WRITE, 32'h0000_3084, 32'hcafe_f00d);
    drain();
    m = i_test_mem.req_count;
    send_req(MEM_READ, 32'h0000_5088, '0);
    drain();
    checks++;
    if (i_test_mem.wb_addr_q.size() != 1 || i_test_mem.req_count != m + 2) begin
      errors++;
      $display("CHECK FAILED %s: expected 1 write-back of 2 requests, actual %0d of %0d",
               test_name, i_test_mem.wb_addr_q.size(), i_test_mem.req_count - m);
    end
    end_test();

    start_test("random_traffic");
    stall_en = 1'b1;
    for (int n = 0; n < RAND_OPS; n++) begin
      a = (($urandom_range(0, 1) != 0) ? 32'h0000_9000 : 32'h0000_4000)
          + 32'($urandom_range(0, 3) * 16) + 32'($urandom_range(0, 3) * 4);
      op = $urandom_range(0, 9);
      if (op < 5) begin
        send_req(MEM_READ, a, '0);
      end else if (op < 8) begin
        send_req(MEM_WRITE, a, $urandom());
      end else begin
        // Init a whole line so no word is left undefined
        for (int k = 0; k < 4; k++)
          send_req(MEM_INIT, (a & ~32'hf) + 32'(4 * k), $urandom());
      end
    end
    end_test();
    stall_en = 1'b0;

    asrt_fails = i_blocking_cache.i_cache_ctrl.i_cache_ctrl_chk.fail_count;
    if (asrt_fails != 0) begin
      errors += int'(asrt_fails);
      $display("%0d controller handshake assertions failed", asrt_fails);
    end

    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

/* blocking_cache.f */
rtl/cache_pkg.sv
rtl/cache_ctrl.sv
rtl/cache_dpath.sv
rtl/blocking_cache.sv
test/test_mem.sv
test/cache_ctrl_chk.sv
test/tb_blocking_cache.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_blocking_cache
FILELIST = blocking_cache.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
